// ==== source/asym_ram_pkg.sv ====
`default_nettype none

package asym_ram_pkg;

   // Byte lane geometry
   localparam int LANE_W     = 8;
   localparam int LANES      = 4;
   localparam int LANE_SEL_W = 2;

   // Wide port A
   localparam int WORD_W      = 32;
   localparam int WORD_ADDR_W = 6;

   // Narrow port B addresses bytes across all lanes
   localparam int BYTE_ADDR_W = 8;

   // One bank holds one lane of every wide word
   localparam int BANK_ADDR_W = 6;

   // Wide data seen as a port word or as per-bank lanes
   // Lane 0 is the least significant byte
   typedef union packed {
      logic [WORD_W-1:0]            word;
      logic [LANES-1:0][LANE_W-1:0] lanes;
   } wide_word_u;

   // Word port request
   typedef struct packed {
      logic                   en;
      logic                   we;
      logic [WORD_ADDR_W-1:0] addr;
      wide_word_u             wdata;
   } port_a_req_t;

   // Byte port request, address bits 1..0 select the lane
   typedef struct packed {
      logic                   en;
      logic                   we;
      logic [BYTE_ADDR_W-1:0] addr;
      logic [LANE_W-1:0]      wdata;
   } port_b_req_t;

   // Request to one port of one bank
   typedef struct packed {
      logic                   en;
      logic                   we;
      logic [BANK_ADDR_W-1:0] addr;
      logic [LANE_W-1:0]      wdata;
   } bank_req_t;

endpackage

`default_nettype wire

// ==== source/ram_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module ram_bank (
   input  logic                            clk_i,
   input  logic                            reset_i,

   // Port A side of the bank
   input  asym_ram_pkg::bank_req_t         req_a_i,
   output logic [asym_ram_pkg::LANE_W-1:0] rdata_a_o,

   // Port B side of the bank
   input  asym_ram_pkg::bank_req_t         req_b_i,
   output logic [asym_ram_pkg::LANE_W-1:0] rdata_b_o
);

   // Storage for one byte lane
   logic [asym_ram_pkg::LANE_W-1:0] mem [0:(1 << asym_ram_pkg::BANK_ADDR_W)-1];

   // Both ports write here; same-address collisions have no defined result
   always_ff @(posedge clk_i) begin
      if (req_a_i.en && req_a_i.we) begin
         mem[req_a_i.addr] <= req_a_i.wdata;
      end
      if (req_b_i.en && req_b_i.we) begin
         mem[req_b_i.addr] <= req_b_i.wdata;
      end
   end

   // Read-first output of port A, held while en is low
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rdata_a_o <= '0;
      end else if (req_a_i.en) begin
         rdata_a_o <= mem[req_a_i.addr];
      end
   end

   // Read-first output of port B
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rdata_b_o <= '0;
      end else if (req_b_i.en) begin
         rdata_b_o <= mem[req_b_i.addr];
      end
   end

endmodule

`default_nettype wire

// ==== source/lane_steer.sv ====
`timescale 1ns/10ps
`default_nettype none

module lane_steer (
   // Requests from the two ports
   input  asym_ram_pkg::port_a_req_t                                req_a_i,
   input  asym_ram_pkg::port_b_req_t                                req_b_i,

   // Per-lane requests, index n drives bank n
   output asym_ram_pkg::bank_req_t [asym_ram_pkg::LANES-1:0]        bank_a_o,
   output asym_ram_pkg::bank_req_t [asym_ram_pkg::LANES-1:0]        bank_b_o
);

   // Byte address split into bank row and lane
   logic [asym_ram_pkg::BANK_ADDR_W-1:0] b_row;
   logic [asym_ram_pkg::LANE_SEL_W-1:0]  b_lane;

   // One-hot enable for the byte port
   logic [asym_ram_pkg::LANES-1:0]       b_en_vec;

   assign b_row  = req_b_i.addr[asym_ram_pkg::BYTE_ADDR_W-1:asym_ram_pkg::LANE_SEL_W];
   assign b_lane = req_b_i.addr[asym_ram_pkg::LANE_SEL_W-1:0];

   // Only the addressed lane sees the enable
   always_comb begin
      b_en_vec         = '0;
      b_en_vec[b_lane] = req_b_i.en;
   end

   // Word port drives every lane at once
   always_comb begin
      for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
         bank_a_o[n].en    = req_a_i.en;
         bank_a_o[n].we    = req_a_i.we;
         bank_a_o[n].addr  = req_a_i.addr;
         // Write word split per lane through the union
         bank_a_o[n].wdata = req_a_i.wdata.lanes[n];
      end
   end

   // Byte port is broadcast, enable picks the bank
   always_comb begin
      for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
         bank_b_o[n].en    = b_en_vec[n];
         // A bank without en ignores we, so it passes through as is
         bank_b_o[n].we    = req_b_i.we;
         bank_b_o[n].addr  = b_row;
         bank_b_o[n].wdata = req_b_i.wdata;
      end
   end

endmodule

`default_nettype wire

// ==== source/read_assemble.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_assemble (
   input  logic                                                 clk_i,
   input  logic                                                 reset_i,

   // Byte port request, only en and the lane bits are used
   input  asym_ram_pkg::port_b_req_t                            req_b_i,

   // Registered bank outputs, index n comes from bank n
   input  logic [asym_ram_pkg::LANES-1:0][asym_ram_pkg::LANE_W-1:0] bank_rdata_a_i,
   input  logic [asym_ram_pkg::LANES-1:0][asym_ram_pkg::LANE_W-1:0] bank_rdata_b_i,

   // Port read data
   output asym_ram_pkg::wide_word_u                             rdata_a_o,
   output logic [asym_ram_pkg::LANE_W-1:0]                      rdata_b_o
);

   // Lane of the last enabled byte access
   logic [asym_ram_pkg::LANE_SEL_W-1:0] lane_q;

   // Captured on the same edge as the bank output, so both line up
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         lane_q <= '0;
      end else if (req_b_i.en) begin
         lane_q <= req_b_i.addr[asym_ram_pkg::LANE_SEL_W-1:0];
      end
   end

   // Byte port result from the recorded lane
   always_comb begin
      rdata_b_o = bank_rdata_b_i[lane_q];
   end

   // Wide result packed lane by lane, lane 0 at the bottom
   always_comb begin
      for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
         rdata_a_o.lanes[n] = bank_rdata_a_i[n];
      end
   end

endmodule

`default_nettype wire

// ==== source/asym_dp_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module asym_dp_ram (
   input  logic                            clk_i,
   input  logic                            reset_i,

   // Word port A
   input  asym_ram_pkg::port_a_req_t       req_a_i,
   output asym_ram_pkg::wide_word_u        rdata_a_o,

   // Byte port B
   input  asym_ram_pkg::port_b_req_t       req_b_i,
   output logic [asym_ram_pkg::LANE_W-1:0] rdata_b_o
);

   // Steered requests, one per bank and port
   asym_ram_pkg::bank_req_t [asym_ram_pkg::LANES-1:0] bank_a;
   asym_ram_pkg::bank_req_t [asym_ram_pkg::LANES-1:0] bank_b;

   // Registered bank read data
   logic [asym_ram_pkg::LANES-1:0][asym_ram_pkg::LANE_W-1:0] bank_rdata_a;
   logic [asym_ram_pkg::LANES-1:0][asym_ram_pkg::LANE_W-1:0] bank_rdata_b;

   lane_steer u_lane_steer (
      .req_a_i  (req_a_i),
      .req_b_i  (req_b_i),
      .bank_a_o (bank_a),
      .bank_b_o (bank_b)
   );

   // One bank per byte lane
   for (genvar n = 0; n < asym_ram_pkg::LANES; n++) begin : g_bank
      ram_bank u_ram_bank (
         .clk_i     (clk_i),
         .reset_i   (reset_i),
         .req_a_i   (bank_a[n]),
         .rdata_a_o (bank_rdata_a[n]),
         .req_b_i   (bank_b[n]),
         .rdata_b_o (bank_rdata_b[n])
      );
   end

   read_assemble u_read_assemble (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .req_b_i        (req_b_i),
      .bank_rdata_a_i (bank_rdata_a),
      .bank_rdata_b_i (bank_rdata_b),
      .rdata_a_o      (rdata_a_o),
      .rdata_b_o      (rdata_b_o)
   );

endmodule

`default_nettype wire

// ==== tb/asym_dp_ram_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module asym_dp_ram_sva (
   input logic                                              clk_i,
   input logic                                              reset_i,
   input asym_ram_pkg::bank_req_t [asym_ram_pkg::LANES-1:0] bank_a_i,
   input asym_ram_pkg::bank_req_t [asym_ram_pkg::LANES-1:0] bank_b_i,
   input asym_ram_pkg::wide_word_u                          rdata_a_i,
   input logic [asym_ram_pkg::LANE_W-1:0]                   rdata_b_i
);

   // Bank enables gathered per port
   logic [asym_ram_pkg::LANES-1:0] a_en;
   logic [asym_ram_pkg::LANES-1:0] b_en;

   always_comb begin
      for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
         a_en[n] = bank_a_i[n].en;
         b_en[n] = bank_b_i[n].en;
      end
   end

   // Byte port reaches one bank at most
   b_en_onehot: assert property (
      @(posedge clk_i) disable iff (reset_i) $onehot0(b_en)
   ) else $error("More than one port B bank enable is high: %b", b_en);

   // Word port drives all lanes together
   a_en_equal: assert property (
      @(posedge clk_i) disable iff (reset_i) (a_en == '0) || (a_en == '1)
   ) else $error("Port A bank enables differ: %b", a_en);

   // Outputs cleared in the cycle after reset
   reset_clears: assert property (
      @(posedge clk_i) reset_i |=> (rdata_a_i.word == '0) && (rdata_b_i == '0)
   ) else $error("Read outputs not zero after reset: %h %h", rdata_a_i.word, rdata_b_i);

endmodule

bind asym_dp_ram asym_dp_ram_sva u_sva (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .bank_a_i  (bank_a),
   .bank_b_i  (bank_b),
   .rdata_a_i (rdata_a_o),
   .rdata_b_i (rdata_b_o)
);

`default_nettype wire

// ==== tb/asym_dp_ram_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module asym_dp_ram_tb;

   logic                            clk_i;
   logic                            reset_i;
   asym_ram_pkg::port_a_req_t       req_a;
   asym_ram_pkg::port_b_req_t       req_b;
   asym_ram_pkg::wide_word_u        rdata_a;
   logic [asym_ram_pkg::LANE_W-1:0] rdata_b;

   // Byte-array model of the shared storage
   logic [asym_ram_pkg::LANE_W-1:0] ref_mem [0:(1 << asym_ram_pkg::BYTE_ADDR_W)-1];
   bit                              known   [0:(1 << asym_ram_pkg::BYTE_ADDR_W)-1];

   // Expected outputs, held between enables like the DUT
   asym_ram_pkg::wide_word_u        exp_a;
   logic [asym_ram_pkg::LANE_W-1:0] exp_b;
   bit                              exp_a_ok = 1'b0;
   bit                              exp_b_ok = 1'b0;
   bit                              checking = 1'b0;

   // Enabled accesses seen by the model and those already compared
   int     seen_a       = 0;
   int     seen_b       = 0;
   int     done_a       = 0;
   int     done_b       = 0;

   int     checks       = 0;
   int     errors       = 0;
   int     tests        = 0;
   int     failed_tests = 0;
   int     test_errors  = 0;
   string  cur_test     = "reset";
   integer seed;

   asym_dp_ram UUT (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_a_i   (req_a),
      .rdata_a_o (rdata_a),
      .req_b_i   (req_b),
      .rdata_b_o (rdata_b)
   );

   // 8 ns clock
   initial begin
      clk_i = 1'b0;
      forever begin
         #4 clk_i = ~clk_i;
      end
   end

   // Expected word of a port A read, lane 0 from the lowest byte address
   function automatic asym_ram_pkg::wide_word_u ref_word(
      input logic [asym_ram_pkg::WORD_ADDR_W-1:0] addr
   );
      asym_ram_pkg::wide_word_u w;
      for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
         w.lanes[n] = ref_mem[int'(addr) * asym_ram_pkg::LANES + n];
      end
      return w;
   endfunction

   // Expected byte of a port B read
   function automatic logic [asym_ram_pkg::LANE_W-1:0] ref_byte(
      input logic [asym_ram_pkg::BYTE_ADDR_W-1:0] addr
   );
      return ref_mem[addr];
   endfunction

   // A word is only predictable once all four bytes were written
   function automatic bit word_known(input logic [asym_ram_pkg::WORD_ADDR_W-1:0] addr);
      bit ok;
      ok = 1'b1;
      for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
         ok = ok & known[int'(addr) * asym_ram_pkg::LANES + n];
      end
      return ok;
   endfunction

   // Model update at each edge, reads take the old content
   always @(posedge clk_i) begin
      if (reset_i) begin
         exp_a.word = '0;
         exp_b      = '0;
         exp_a_ok   = 1'b1;
         exp_b_ok   = 1'b1;
         checking   = 1'b1;
      end else begin
         if (req_a.en) begin
            exp_a    = ref_word(req_a.addr);
            exp_a_ok = word_known(req_a.addr);
            seen_a++;
         end
         if (req_b.en) begin
            exp_b    = ref_byte(req_b.addr);
            exp_b_ok = known[req_b.addr];
            seen_b++;
         end
         if (req_a.en && req_a.we) begin
            for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
               ref_mem[int'(req_a.addr) * asym_ram_pkg::LANES + n] = req_a.wdata.lanes[n];
               known[int'(req_a.addr) * asym_ram_pkg::LANES + n]   = 1'b1;
            end
         end
         if (req_b.en && req_b.we) begin
            ref_mem[req_b.addr] = req_b.wdata;
            known[req_b.addr]   = 1'b1;
         end
      end
   end

   task automatic check_word(
      input string                    name,
      input asym_ram_pkg::wide_word_u expected,
      input asym_ram_pkg::wide_word_u actual
   );
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: port A expected %h, actual %h",
                  name, expected.word, actual.word);
      end
   endtask

   task automatic check_byte(
      input string                           name,
      input logic [asym_ram_pkg::LANE_W-1:0] expected,
      input logic [asym_ram_pkg::LANE_W-1:0] actual
   );
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: port B expected %h, actual %h", name, expected, actual);
      end
   endtask

   // Outputs are settled at the falling edge; held values are checked too
   always @(negedge clk_i) begin
      if (checking) begin
         if (exp_a_ok) begin
            check_word(cur_test, exp_a, rdata_a);
         end
         if (exp_b_ok) begin
            check_byte(cur_test, exp_b, rdata_b);
         end
         done_a = seen_a;
         done_b = seen_b;
      end
   end

   function automatic asym_ram_pkg::port_a_req_t make_a(
      input logic                      en,
      input logic                      we,
      input int                        addr,
      input logic [asym_ram_pkg::WORD_W-1:0] data
   );
      asym_ram_pkg::port_a_req_t r;
      r.en         = en;
      r.we         = we;
      r.addr       = addr[asym_ram_pkg::WORD_ADDR_W-1:0];
      r.wdata.word = data;
      return r;
   endfunction

   function automatic asym_ram_pkg::port_b_req_t make_b(
      input logic                            en,
      input logic                            we,
      input int                              addr,
      input logic [asym_ram_pkg::LANE_W-1:0] data
   );
      asym_ram_pkg::port_b_req_t r;
      r.en    = en;
      r.we    = we;
      r.addr  = addr[asym_ram_pkg::BYTE_ADDR_W-1:0];
      r.wdata = data;
      return r;
   endfunction

   function automatic asym_ram_pkg::port_a_req_t idle_a();
      return make_a(1'b0, 1'b0, 0, '0);
   endfunction

   function automatic asym_ram_pkg::port_b_req_t idle_b();
      return make_b(1'b0, 1'b0, 0, '0);
   endfunction

   // Fill value depends on the whole byte address
   function automatic logic [asym_ram_pkg::WORD_W-1:0] fill_word(input int w);
      asym_ram_pkg::wide_word_u v;
      int                       b;
      for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
         b          = (w * asym_ram_pkg::LANES + n) * 29 + 60;
         v.lanes[n] = b[asym_ram_pkg::LANE_W-1:0];
      end
      return v.word;
   endfunction

   task automatic apply(
      input asym_ram_pkg::port_a_req_t a,
      input asym_ram_pkg::port_b_req_t b
   );
      @(posedge clk_i);
      req_a <= a;
      req_b <= b;
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = errors;
   endtask

   // Go idle, then wait until every issued read has been compared
   task automatic finish_test();
      int cnt;
      apply(idle_a(), idle_b());
      cnt = 0;
      while ((done_a != seen_a || done_b != seen_b) && cnt < 16) begin
         @(posedge clk_i);
         cnt++;
      end
      if (done_a != seen_a || done_b != seen_b) begin
         $display("Timeout: reads issued in test %s were never compared", cur_test);
         errors++;
      end
      tests++;
      if (errors != test_errors) begin
         failed_tests++;
      end
      $display("Test %-14s %s, %0d mismatches", cur_test,
               (errors == test_errors) ? "ok" : "failed", errors - test_errors);
   endtask

   task automatic random_traffic(input int cycles);
      int                        r;
      int                        d;
      asym_ram_pkg::port_a_req_t a;
      asym_ram_pkg::port_b_req_t b;
      for (int i = 0; i < cycles; i++) begin
         r = $random(seed);
         d = $random(seed);
         a = make_a(r[0], r[1], int'(r[7:2]), d);
         b = make_b(r[8], r[9], int'(r[17:10]), r[25:18]);
         // Never both ports writing one byte in the same cycle
         if (a.en && a.we && b.en && b.we &&
             b.addr[asym_ram_pkg::BYTE_ADDR_W-1:asym_ram_pkg::LANE_SEL_W] == a.addr) begin
            b.we = 1'b0;
         end
         apply(a, b);
      end
   endtask

   initial begin
      int words [4];
      int d;
      words   = '{5, 17, 42, 63};
      seed    = 32'hc48a;
      reset_i = 1'b1;
      req_a   = '0;
      req_b   = '0;
      repeat (2) @(posedge clk_i);
      reset_i <= 1'b0;

      // Outputs cleared by reset
      start_test("reset");
      repeat (3) apply(idle_a(), idle_b());
      finish_test();

      // Whole memory through the word port, read back byte by byte
      start_test("wide_to_byte");
      for (int w = 0; w < (1 << asym_ram_pkg::WORD_ADDR_W); w++) begin
         apply(make_a(1'b1, 1'b1, w, fill_word(w)), idle_b());
      end
      for (int b = 0; b < (1 << asym_ram_pkg::BYTE_ADDR_W); b++) begin
         apply(idle_a(), make_b(1'b1, 1'b0, b, '0));
      end
      finish_test();

      start_test("byte_to_wide");
      foreach (words[i]) begin
         for (int n = 0; n < asym_ram_pkg::LANES; n++) begin
            d = $random(seed);
            apply(idle_a(), make_b(1'b1, 1'b1, words[i] * asym_ram_pkg::LANES + n, d[7:0]));
         end
      end
      foreach (words[i]) begin
         apply(make_a(1'b1, 1'b0, words[i], '0), idle_b());
      end
      finish_test();

      start_test("read_first");
      apply(make_a(1'b1, 1'b1, 9, 32'hdead_beef), idle_b());
      apply(make_a(1'b1, 1'b0, 9, '0), idle_b());
      apply(idle_a(), make_b(1'b1, 1'b1, 8'h51, 8'ha5));
      apply(idle_a(), make_b(1'b1, 1'b0, 8'h51, '0));
      // Cross-port pairs on the same word
      apply(make_a(1'b1, 1'b1, 20, 32'h0bad_cafe), make_b(1'b1, 1'b0, 82, '0));
      apply(make_a(1'b1, 1'b0, 20, '0), make_b(1'b1, 1'b0, 82, '0));
      apply(make_a(1'b1, 1'b0, 30, '0), make_b(1'b1, 1'b1, 121, 8'h77));
      apply(make_a(1'b1, 1'b0, 30, '0), idle_b());
      finish_test();

      // Lane 3 on port B, then en low with moving addresses and we set
      start_test("hold");
      apply(make_a(1'b1, 1'b0, 12, '0), make_b(1'b1, 1'b0, 8'hc7, '0));
      for (int i = 0; i < 6; i++) begin
         apply(make_a(1'b0, 1'b1, i, 32'hffff_ffff), make_b(1'b0, 1'b1, i, 8'hff));
      end
      for (int i = 0; i < 4; i++) begin
         apply(make_a(1'b1, 1'b0, 40 + i, '0), make_b(1'b0, 1'b0, i, '0));
      end
      for (int i = 0; i < 6; i++) begin
         apply(make_a(1'b1, 1'b0, i, '0), make_b(1'b1, 1'b0, i, '0));
      end
      finish_test();

      start_test("random");
      random_traffic(400);
      finish_test();

      if (checks == 0) begin
         $display("No read data was compared during the run");
         errors++;
      end
      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests, failed_tests, checks, errors);
      if (errors == 0 && failed_tests == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== asym_dp_ram.f ====
source/asym_ram_pkg.sv
source/ram_bank.sv
source/lane_steer.sv
source/read_assemble.sv
source/asym_dp_ram.sv
tb/asym_dp_ram_sva.sv
tb/asym_dp_ram_tb.sv
